//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_valu
FLIST    = vlog.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = STATUS: FAIL

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for failure"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb_clkgen.sv
module tb_clkgen
(
   output logic clk_o
);

   timeunit 1ns;
   timeprecision 1ps;

   // Half of the 8 ns period
   localparam int HALF_NS = 4;

   initial
   begin
      clk_o = 1'b0;
      forever
         #(HALF_NS) clk_o = ~clk_o;
   end

endmodule

//--- tb_valu.sv
module tb_valu
   import valu_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   // Test sizes
   localparam int N_RAND = 200;
   localparam int N_RED  = 40;
   localparam int N_BP   = 9;
   localparam int N_STRB = 8;
   // Per command: 12 operand writes, CTRL, a few polls, 5 result reads
   localparam int TRANS_PER_CMD = 22;
   localparam int N_TRANS       = (N_RAND + N_RED + N_BP + N_STRB) * TRANS_PER_CMD + 10;
   localparam int CYCLE_LIMIT   = N_TRANS * 40 + 200;

   logic      clk;
   logic      rst_n;
   axil_req_t req;
   axil_rsp_t rsp;

   // Shadow of the operand banks, 0 is A, 1 is B, 2 is C
   logic [31:0] ops [3][LANE_NUM];
   // Expected words in read order, four lanes then the mask
   logic [31:0] exp_q [$];

   int checks = 0;
   int errors = 0;
   int checks_at_start;
   int errors_at_start;
   int cycles = 0;

   tb_clkgen u_clkgen (
      .clk_o (clk)
   );

   valu_top UUT (
      .clk        (clk),
      .rst_n_i    (rst_n),
      .axil_req_i (req),
      .axil_rsp_o (rsp)
   );

   // Run limit
   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   task automatic compare_word(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   // AW and W together, then wait for B
   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
      @(negedge clk);
      req.awaddr  = addr;
      req.awvalid = 1'b1;
      req.wdata   = data;
      req.wstrb   = strb;
      req.wvalid  = 1'b1;
      req.bready  = 1'b1;
      // Readies settle within the low phase
      #1;
      compare_word("awready", 32'h1, 32'(rsp.awready));
      compare_word("wready", 32'h1, 32'(rsp.wready));
      do
         @(negedge clk);
      while (!rsp.bvalid);
      resp        = rsp.bresp;
      req.awvalid = 1'b0;
      req.wvalid  = 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      @(negedge clk);
      req.araddr  = addr;
      req.arvalid = 1'b1;
      req.rready  = 1'b1;
      #1;
      compare_word("arready", 32'h1, 32'(rsp.arready));
      do
         @(negedge clk);
      while (!rsp.rvalid);
      data        = rsp.rdata;
      resp        = rsp.rresp;
      req.arvalid = 1'b0;
   endtask

   task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp_data,
                              input logic [1:0] exp_resp, input string name);
      logic [31:0] data;
      logic [1:0]  resp;
      read_reg(addr, data, resp);
      compare_word({"rdata ", name}, exp_data, data);
      compare_word({"rresp ", name}, 32'(exp_resp), 32'(resp));
   endtask

   // Updates the shadow with the same byte strobes
   task automatic write_operand(input int bank, input int lane, input logic [31:0] data,
                                input logic [3:0] strb);
      logic [1:0] resp;
      write_reg(REG_A + 8'(16 * bank + 4 * lane), data, strb, resp);
      compare_word("bresp operand", 32'(RESP_OKAY), 32'(resp));
      for (int i = 0; i < 4; i++)
      begin
         if (strb[i])
            ops[bank][lane][8*i +: 8] = data[8*i +: 8];
      end
   endtask

   task automatic randomize_operands();
      for (int bank = 0; bank < 3; bank++)
         for (int lane = 0; lane < LANE_NUM; lane++)
            write_operand(bank, lane, $urandom(), 4'hF);
   endtask

   function automatic longint sext(input logic [63:0] v, input int w);
      if (v[w-1])
         return longint'(v) - (longint'(1) << w);
      return longint'(v);
   endfunction

   // Expected lane word, element by element
   function automatic logic [31:0] model_lane(input opcode_e op, input sew_e sew,
                                              input logic red, input logic [31:0] a,
                                              input logic [31:0] b, input logic [31:0] c);
      int          w;
      logic [63:0] msk;
      logic [63:0] ea;
      logic [63:0] eb;
      logic [63:0] ec;
      logic [63:0] e;
      longint      sa;
      longint      sb;
      logic [31:0] word;
      logic [31:0] sum;
      w    = (sew == SEW8) ? 8 : (sew == SEW16) ? 16 : 32;
      msk  = (64'd1 << w) - 64'd1;
      word = '0;
      sum  = '0;
      for (int i = 0; i < 32 / w; i++)
      begin
         ea = (64'(a) >> (i * w)) & msk;
         eb = (64'(b) >> (i * w)) & msk;
         ec = (64'(c) >> (i * w)) & msk;
         sa = sext(ea, w);
         sb = sext(eb, w);
         case (op)
            ADD:     e = ea + eb;
            SUB:     e = ea - eb;
            AND:     e = ea & eb;
            OR:      e = ea | eb;
            XOR:     e = ea ^ eb;
            MIN:     e = (sa <= sb) ? ea : eb;
            MAX:     e = (sa >= sb) ? ea : eb;
            MUL:     e = ea * eb;
            MACC:    e = ea * eb + ec;
            SLT:     e = (sa < sb) ? 64'd1 : 64'd0;
            default: e = '0;
         endcase
         // Wrap to the element width
         e    = e & msk;
         word = word | 32'(e << (i * w));
         // Reduction sums unsigned elements, mod 2^32
         sum  = sum + 32'(e);
      end
      return red ? sum : word;
   endfunction

   task automatic issue_cmd(input opcode_e op, input sew_e sew, input logic red,
                            input logic [1:0] exp_resp);
      logic [31:0] ctrl;
      logic [1:0]  resp;
      logic [31:0] lane_word;
      logic [31:0] mask;
      ctrl = {23'd0, red, 2'b00, sew, op};
      write_reg(REG_CTRL, ctrl, 4'hF, resp);
      compare_word("bresp CTRL", 32'(exp_resp), 32'(resp));
      if (exp_resp == RESP_OKAY)
      begin
         mask = '0;
         for (int l = 0; l < LANE_NUM; l++)
         begin
            lane_word = model_lane(op, sew, red, ops[0][l], ops[1][l], ops[2][l]);
            mask[l]   = lane_word[0];
            exp_q.push_back(lane_word);
         end
         exp_q.push_back(mask);
      end
   endtask

   // Poll STATUS until a result is held
   task automatic wait_result();
      logic [31:0] st;
      logic [1:0]  resp;
      do
         read_reg(REG_STATUS, st, resp);
      while (st[7:4] == 4'd0);
   endtask

   // Reads one result and its mask, the MASK read pops it
   task automatic check_result();
      logic [31:0] exp;
      wait_result();
      for (int l = 0; l <= LANE_NUM; l++)
      begin
         exp = exp_q.pop_front();
         if (l < LANE_NUM)
            read_expect(REG_RES + 8'(4 * l), exp, RESP_OKAY, $sformatf("RES lane %0d", l));
         else
            read_expect(REG_MASK, exp, RESP_OKAY, "MASK");
      end
   endtask

   task automatic start_test();
      checks_at_start = checks;
      errors_at_start = errors;
   endtask

   task automatic end_test(input string name);
      $display("Test %s: %0d checks, %0d errors", name, checks - checks_at_start,
               errors - errors_at_start);
   endtask

   initial
   begin
      logic [1:0] resp;
      void'($urandom(18));
      req   = '0;
      rst_n = 1'b0;
      for (int b = 0; b < 3; b++)
         for (int l = 0; l < LANE_NUM; l++)
            ops[b][l] = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Empty FIFOs and address decode
      start_test();
      read_expect(REG_STATUS, 32'h0, RESP_OKAY, "STATUS");
      read_expect(REG_RES, 32'h0, RESP_SLVERR, "RES lane 0");
      read_expect(REG_RES + 8'hC, 32'h0, RESP_SLVERR, "RES lane 3");
      read_expect(REG_MASK, 32'h0, RESP_SLVERR, "MASK");
      read_expect(8'h74, 32'h0, RESP_SLVERR, "unmapped");
      write_reg(8'h70, $urandom(), 4'hF, resp);
      compare_word("bresp unmapped", 32'(RESP_SLVERR), 32'(resp));
      write_reg(REG_STATUS, $urandom(), 4'hF, resp);
      compare_word("bresp STATUS", 32'(RESP_SLVERR), 32'(resp));
      end_test("after reset");

      // Every opcode at every SEW
      start_test();
      for (int i = 0; i < N_RAND; i++)
      begin
         randomize_operands();
         issue_cmd(opcode_e'(i % 10), sew_e'((i / 10) % 3), 1'b0, RESP_OKAY);
         check_result();
      end
      end_test("random commands");

      start_test();
      for (int i = 0; i < N_RED; i++)
      begin
         randomize_operands();
         issue_cmd(opcode_e'($urandom_range(0, 9)), sew_e'(i % 3), 1'b1, RESP_OKAY);
         check_result();
      end
      end_test("reduction");

      // Four results fill the result FIFO, one command waits
      start_test();
      for (int i = 0; i <= RES_DEPTH; i++)
      begin
         randomize_operands();
         issue_cmd(opcode_e'($urandom_range(0, 9)), sew_e'($urandom_range(0, 2)),
                   1'($urandom_range(0, 1)), RESP_OKAY);
      end
      read_expect(REG_STATUS, 32'h41, RESP_OKAY, "STATUS");
      for (int i = 1; i < CMD_DEPTH; i++)
      begin
         randomize_operands();
         issue_cmd(opcode_e'($urandom_range(0, 9)), sew_e'($urandom_range(0, 2)),
                   1'($urandom_range(0, 1)), RESP_OKAY);
      end
      read_expect(REG_STATUS, 32'h44, RESP_OKAY, "STATUS");
      // Command FIFO full now
      issue_cmd(ADD, SEW32, 1'b0, RESP_SLVERR);
      read_expect(REG_STATUS, 32'h44, RESP_OKAY, "STATUS");
      for (int i = 0; i < RES_DEPTH + CMD_DEPTH; i++)
         check_result();
      read_expect(REG_STATUS, 32'h0, RESP_OKAY, "STATUS");
      end_test("back-pressure");

      // Partial writes over known words, seen through AND
      start_test();
      for (int r = 0; r < N_STRB; r++)
      begin
         randomize_operands();
         for (int l = 0; l < LANE_NUM; l++)
         begin
            write_operand(0, l, $urandom(), 4'($urandom_range(0, 15)));
            write_operand(1, l, $urandom(), 4'($urandom_range(0, 15)));
         end
         issue_cmd(AND, SEW32, 1'b0, RESP_OKAY);
         check_result();
      end
      end_test("byte strobes");

      $display("Total: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

//--- valu_alu.sv
module valu_alu
   import valu_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n_i,
   input  valu_cmd_t            cmd_data_i,
   input  logic                 cmd_empty_i,
   input  logic [RES_CNT_W-1:0] res_count_i,
   output logic                 cmd_pop_o,
   output logic                 res_push_o,
   output valu_res_t            res_data_o
);

   // Commands popped but not yet pushed as results
   logic [RES_CNT_W-1:0] inflight_q;
   logic [RES_CNT_W:0]   used_slots;

   logic [LANE_NUM-1:0]               lane_vld;
   logic [LANE_NUM-1:0][OP_WIDTH-1:0] lane_res;

   // Credit check, every popped command owns a result slot
   assign used_slots = {1'b0, res_count_i} + {1'b0, inflight_q};
   assign cmd_pop_o  = !cmd_empty_i && (used_slots < RES_DEPTH);

   // Lanes run in lockstep
   assign res_push_o = &lane_vld;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         inflight_q <= '0;
      else
         case ({cmd_pop_o, res_push_o})
            2'b10:   inflight_q <= inflight_q + 1'b1;
            2'b01:   inflight_q <= inflight_q - 1'b1;
            default: inflight_q <= inflight_q;
         endcase
   end

   // Shared opcode, per-lane operands
   for (genvar g = 0; g < LANE_NUM; g++)
   begin : g_lane
      valu_lane u_lane (
         .clk      (clk),
         .rst_n_i  (rst_n_i),
         .vld_i    (cmd_pop_o),
         .opcode_i (cmd_data_i.opcode),
         .sew_i    (cmd_data_i.sew),
         .reduce_i (cmd_data_i.reduce),
         .op1_i    (cmd_data_i.a[g]),
         .op2_i    (cmd_data_i.b[g]),
         .op3_i    (cmd_data_i.c[g]),
         .vld_o    (lane_vld[g]),
         .result_o (lane_res[g])
      );
   end

   // Mask bit is bit 0 of each lane
   always_comb
   begin
      res_data_o.result = lane_res;
      for (int i = 0; i < LANE_NUM; i++)
         res_data_o.mask[i] = lane_res[i][0];
   end

endmodule

//--- valu_axil_front.sv
module valu_axil_front
   import valu_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n_i,
   input  axil_req_t            axil_req_i,
   input  logic                 cmd_full_i,
   input  logic [CMD_CNT_W-1:0] cmd_count_i,
   input  valu_res_t            res_data_i,
   input  logic                 res_empty_i,
   input  logic [RES_CNT_W-1:0] res_count_i,
   output axil_rsp_t            axil_rsp_o,
   output logic                 cmd_push_o,
   output valu_cmd_t            cmd_data_o,
   output logic                 res_pop_o
);

   // Operand registers, one word per lane and bank
   logic [LANE_NUM-1:0][OP_WIDTH-1:0] opa_q;
   logic [LANE_NUM-1:0][OP_WIDTH-1:0] opb_q;
   logic [LANE_NUM-1:0][OP_WIDTH-1:0] opc_q;

   // Response channel state
   logic        bvalid_q;
   logic [1:0]  bresp_q;
   logic        rvalid_q;
   logic [31:0] rdata_q;
   logic [1:0]  rresp_q;

   logic                  wr_hs;
   logic                  rd_hs;
   logic [ADDR_WIDTH-1:0] wr_base;
   logic [ADDR_WIDTH-1:0] rd_base;
   logic [1:0]            wr_lane;
   logic [1:0]            rd_lane;
   logic                  wr_aligned;
   logic                  rd_aligned;
   logic                  wr_ctrl;
   logic                  wr_a;
   logic                  wr_b;
   logic                  wr_c;
   logic                  wr_err;
   logic                  rd_status;
   logic                  rd_res;
   logic                  rd_mask;
   logic [31:0]           rd_data;
   logic [1:0]            rd_resp;

   // Merge write data into a word under the byte strobes
   function automatic logic [OP_WIDTH-1:0] apply_strb(input logic [OP_WIDTH-1:0] old_w,
                                                      input logic [31:0] data,
                                                      input logic [3:0] strb);
      logic [OP_WIDTH-1:0] w;
      w = old_w;
      for (int i = 0; i < 4; i++)
      begin
         if (strb[i])
            w[8*i +: 8] = data[8*i +: 8];
      end
      return w;
   endfunction

   // AW and W are only taken together, one write in flight
   assign wr_hs = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
   assign rd_hs = axil_req_i.arvalid && !rvalid_q;

   // Write decode, lane index from bits 3:2
   assign wr_base    = {axil_req_i.awaddr[ADDR_WIDTH-1:4], 4'h0};
   assign wr_lane    = axil_req_i.awaddr[3:2];
   assign wr_aligned = (axil_req_i.awaddr[1:0] == 2'b00);
   assign wr_ctrl    = (axil_req_i.awaddr == REG_CTRL);
   assign wr_a       = (wr_base == REG_A) && wr_aligned;
   assign wr_b       = (wr_base == REG_B) && wr_aligned;
   assign wr_c       = (wr_base == REG_C) && wr_aligned;
   // Unmapped, read-only, or a command with no room
   assign wr_err     = !(wr_ctrl || wr_a || wr_b || wr_c) || (wr_ctrl && cmd_full_i);

   // Read decode
   assign rd_base    = {axil_req_i.araddr[ADDR_WIDTH-1:4], 4'h0};
   assign rd_lane    = axil_req_i.araddr[3:2];
   assign rd_aligned = (axil_req_i.araddr[1:0] == 2'b00);
   assign rd_status  = (axil_req_i.araddr == REG_STATUS);
   assign rd_res     = (rd_base == REG_RES) && rd_aligned;
   assign rd_mask    = (axil_req_i.araddr == REG_MASK);

   // Command built from CTRL fields plus current operands
   assign cmd_push_o        = wr_hs && wr_ctrl && !cmd_full_i;
   assign cmd_data_o.opcode = opcode_e'(axil_req_i.wdata[3:0]);
   assign cmd_data_o.sew    = sew_e'(axil_req_i.wdata[5:4]);
   assign cmd_data_o.reduce = axil_req_i.wdata[8];
   assign cmd_data_o.a      = opa_q;
   assign cmd_data_o.b      = opb_q;
   assign cmd_data_o.c      = opc_q;

   // MASK read retires the head result
   assign res_pop_o = rd_hs && rd_mask && !res_empty_i;

   always_comb
   begin
      rd_data = '0;
      rd_resp = RESP_OKAY;
      if (rd_status)
         rd_data = {24'h0, 4'(res_count_i), 4'(cmd_count_i)};
      else if (rd_res || rd_mask)
      begin
         // Nothing to return from an empty result FIFO
         if (res_empty_i)
            rd_resp = RESP_SLVERR;
         else if (rd_res)
            rd_data = res_data_i.result[rd_lane];
         else
            rd_data = 32'(res_data_i.mask);
      end
      else
         rd_resp = RESP_SLVERR;
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         opa_q <= '0;
         opb_q <= '0;
         opc_q <= '0;
      end
      else if (wr_hs)
      begin
         if (wr_a)
            opa_q[wr_lane] <= apply_strb(opa_q[wr_lane], axil_req_i.wdata, axil_req_i.wstrb);
         if (wr_b)
            opb_q[wr_lane] <= apply_strb(opb_q[wr_lane], axil_req_i.wdata, axil_req_i.wstrb);
         if (wr_c)
            opc_q[wr_lane] <= apply_strb(opc_q[wr_lane], axil_req_i.wdata, axil_req_i.wstrb);
      end
   end

   // B channel, held until bready
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         bvalid_q <= 1'b0;
         bresp_q  <= RESP_OKAY;
      end
      else if (wr_hs)
      begin
         bvalid_q <= 1'b1;
         bresp_q  <= wr_err ? RESP_SLVERR : RESP_OKAY;
      end
      else if (axil_req_i.bready)
         bvalid_q <= 1'b0;
   end

   // R channel, held until rready
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rvalid_q <= 1'b0;
         rdata_q  <= '0;
         rresp_q  <= RESP_OKAY;
      end
      else if (rd_hs)
      begin
         rvalid_q <= 1'b1;
         rdata_q  <= rd_data;
         rresp_q  <= rd_resp;
      end
      else if (axil_req_i.rready)
         rvalid_q <= 1'b0;
   end

   always_comb
   begin
      axil_rsp_o.awready = axil_req_i.wvalid && !bvalid_q;
      axil_rsp_o.wready  = axil_req_i.awvalid && !bvalid_q;
      axil_rsp_o.bresp   = bresp_q;
      axil_rsp_o.bvalid  = bvalid_q;
      axil_rsp_o.arready = !rvalid_q;
      axil_rsp_o.rdata   = rdata_q;
      axil_rsp_o.rresp   = rresp_q;
      axil_rsp_o.rvalid  = rvalid_q;
   end

endmodule

//--- valu_fifo.sv
module valu_fifo
#(
   parameter type data_t = logic,
   parameter int  DEPTH  = 4
)
(
   input  logic                       clk,
   input  logic                       rst_n_i,
   input  logic                       push_i,
   input  data_t                      data_i,
   input  logic                       pop_i,
   output data_t                      data_o,
   output logic                       full_o,
   output logic                       empty_o,
   output logic [$clog2(DEPTH+1)-1:0] count_o
);

   // Storage, payload only
   data_t mem [DEPTH];

   logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
   logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
   logic [$clog2(DEPTH+1)-1:0] count_q;
   logic                       do_push;
   logic                       do_pop;

   // Push on full and pop on empty are dropped
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;

   assign full_o  = (count_q == DEPTH);
   assign empty_o = (count_q == '0);
   assign count_o = count_q;

   // First word falls through
   assign data_o = mem[rd_ptr_q];

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr_q] <= data_i;
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         // Pointers wrap at DEPTH
         if (do_push)
            wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
         if (do_pop)
            rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

//--- valu_lane.sv
module valu_lane
   import valu_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n_i,
   input  logic                vld_i,
   input  opcode_e             opcode_i,
   input  sew_e                sew_i,
   input  logic                reduce_i,
   input  logic [OP_WIDTH-1:0] op1_i,
   input  logic [OP_WIDTH-1:0] op2_i,
   input  logic [OP_WIDTH-1:0] op3_i,
   output logic                vld_o,
   output logic [OP_WIDTH-1:0] result_o
);

   // Operand and result views
   valu_elem_u a_u;
   valu_elem_u b_u;
   valu_elem_u c_u;
   valu_elem_u r_u;

   // Stage one registers
   logic       s1_vld_q;
   valu_elem_u s1_res_q;
   sew_e       s1_sew_q;
   logic       s1_reduce_q;

   logic [OP_WIDTH-1:0] red_sum;
   logic [OP_WIDTH-1:0] s2_res;

   // One element op on sign-extended operands
   // Caller keeps the low bits of its width, so wrap is free
   function automatic logic [31:0] elem_op(input opcode_e op,
                                           input logic signed [31:0] a,
                                           input logic signed [31:0] b,
                                           input logic signed [31:0] c);
      case (op)
         ADD:     return a + b;
         SUB:     return a - b;
         AND:     return a & b;
         OR:      return a | b;
         XOR:     return a ^ b;
         MIN:     return (a < b) ? a : b;
         MAX:     return (a < b) ? b : a;
         MUL:     return a * b;
         MACC:    return a * b + c;
         SLT:     return {31'b0, (a < b)};
         // Unknown opcodes give zero
         default: return '0;
      endcase
   endfunction

   assign a_u.w32 = op1_i;
   assign b_u.w32 = op2_i;
   assign c_u.w32 = op3_i;

   // Element results at the selected width
   always_comb
   begin
      logic [31:0] tmp;
      r_u.w32 = '0;
      case (sew_i)
         SEW8:
         begin
            for (int i = 0; i < 4; i++)
            begin
               tmp = elem_op(opcode_i, 32'($signed(a_u.b8[i])),
                             32'($signed(b_u.b8[i])), 32'($signed(c_u.b8[i])));
               r_u.b8[i] = tmp[7:0];
            end
         end
         SEW16:
         begin
            for (int i = 0; i < 2; i++)
            begin
               tmp = elem_op(opcode_i, 32'($signed(a_u.h16[i])),
                             32'($signed(b_u.h16[i])), 32'($signed(c_u.h16[i])));
               r_u.h16[i] = tmp[15:0];
            end
         end
         // SEW32 and the unused code
         default: r_u.w32 = elem_op(opcode_i, a_u.w32, b_u.w32, c_u.w32);
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         s1_vld_q <= 1'b0;
      else
         s1_vld_q <= vld_i;
   end

   // Capture only on a new command
   always_ff @(posedge clk)
   begin
      if (vld_i)
      begin
         s1_res_q    <= r_u;
         s1_sew_q    <= sew_i;
         s1_reduce_q <= reduce_i;
      end
   end

   // Lane reduction, elements read as unsigned
   always_comb
   begin
      red_sum = '0;
      case (s1_sew_q)
         SEW8:
            for (int i = 0; i < 4; i++)
               red_sum = red_sum + OP_WIDTH'(s1_res_q.b8[i]);
         SEW16:
            for (int i = 0; i < 2; i++)
               red_sum = red_sum + OP_WIDTH'(s1_res_q.h16[i]);
         default: red_sum = s1_res_q.w32;
      endcase
   end

   assign s2_res = s1_reduce_q ? red_sum : s1_res_q.w32;

   // Stage two
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         vld_o <= 1'b0;
      else
         vld_o <= s1_vld_q;
   end

   always_ff @(posedge clk)
   begin
      if (s1_vld_q)
         result_o <= s2_res;
   end

endmodule

//--- valu_pkg.sv
package valu_pkg;

   // Vector geometry
   localparam int LANE_NUM   = 4;
   localparam int OP_WIDTH   = 32;

   // Buffer depths and the matching count widths
   localparam int CMD_DEPTH  = 4;
   localparam int RES_DEPTH  = 4;
   localparam int CMD_CNT_W  = $clog2(CMD_DEPTH + 1);
   localparam int RES_CNT_W  = $clog2(RES_DEPTH + 1);

   // AXI4-Lite address map
   localparam int ADDR_WIDTH = 8;
   localparam logic [ADDR_WIDTH-1:0] REG_CTRL   = 8'h00;
   localparam logic [ADDR_WIDTH-1:0] REG_A      = 8'h10;
   localparam logic [ADDR_WIDTH-1:0] REG_B      = 8'h20;
   localparam logic [ADDR_WIDTH-1:0] REG_C      = 8'h30;
   localparam logic [ADDR_WIDTH-1:0] REG_STATUS = 8'h40;
   localparam logic [ADDR_WIDTH-1:0] REG_RES    = 8'h50;
   localparam logic [ADDR_WIDTH-1:0] REG_MASK   = 8'h60;

   // Response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   // Element width, one value for input and output
   typedef enum logic [1:0] {
      SEW8  = 2'd0,
      SEW16 = 2'd1,
      SEW32 = 2'd2
   } sew_e;

   // Vector opcodes, MIN MAX and SLT compare signed
   typedef enum logic [3:0] {
      ADD  = 4'd0,
      SUB  = 4'd1,
      AND  = 4'd2,
      OR   = 4'd3,
      XOR  = 4'd4,
      MIN  = 4'd5,
      MAX  = 4'd6,
      MUL  = 4'd7,
      MACC = 4'd8,
      SLT  = 4'd9
   } opcode_e;

   // One lane word seen at each element width
   typedef union packed {
      logic [3:0][7:0]  b8;
      logic [1:0][15:0] h16;
      logic [31:0]      w32;
   } valu_elem_u;

   // Issued command with a snapshot of all operands
   typedef struct packed {
      opcode_e                           opcode;
      sew_e                              sew;
      logic                              reduce;
      logic [LANE_NUM-1:0][OP_WIDTH-1:0] a;
      logic [LANE_NUM-1:0][OP_WIDTH-1:0] b;
      logic [LANE_NUM-1:0][OP_WIDTH-1:0] c;
   } valu_cmd_t;

   typedef struct packed {
      logic [LANE_NUM-1:0][OP_WIDTH-1:0] result;
      logic [LANE_NUM-1:0]               mask;
   } valu_res_t;

   // Master side of the AXI4-Lite bus
   typedef struct packed {
      logic [ADDR_WIDTH-1:0] awaddr;
      logic                  awvalid;
      logic [31:0]           wdata;
      logic [3:0]            wstrb;
      logic                  wvalid;
      logic                  bready;
      logic [ADDR_WIDTH-1:0] araddr;
      logic                  arvalid;
      logic                  rready;
   } axil_req_t;

   // Slave side of the AXI4-Lite bus
   typedef struct packed {
      logic        awready;
      logic        wready;
      logic [1:0]  bresp;
      logic        bvalid;
      logic        arready;
      logic [31:0] rdata;
      logic [1:0]  rresp;
      logic        rvalid;
   } axil_rsp_t;

endpackage

//--- valu_top.sv
module valu_top
   import valu_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  axil_req_t axil_req_i,
   output axil_rsp_t axil_rsp_o
);

   // Command path
   logic                 cmd_push;
   valu_cmd_t            cmd_wdata;
   logic                 cmd_pop;
   valu_cmd_t            cmd_rdata;
   logic                 cmd_full;
   logic                 cmd_empty;
   logic [CMD_CNT_W-1:0] cmd_count;

   // Result path
   logic                 res_push;
   valu_res_t            res_wdata;
   logic                 res_pop;
   valu_res_t            res_rdata;
   logic                 res_empty;
   logic [RES_CNT_W-1:0] res_count;

   valu_axil_front u_front (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .axil_req_i  (axil_req_i),
      .cmd_full_i  (cmd_full),
      .cmd_count_i (cmd_count),
      .res_data_i  (res_rdata),
      .res_empty_i (res_empty),
      .res_count_i (res_count),
      .axil_rsp_o  (axil_rsp_o),
      .cmd_push_o  (cmd_push),
      .cmd_data_o  (cmd_wdata),
      .res_pop_o   (res_pop)
   );

   valu_fifo #(.data_t(valu_cmd_t), .DEPTH(CMD_DEPTH)) u_cmd_fifo (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .push_i  (cmd_push),
      .data_i  (cmd_wdata),
      .pop_i   (cmd_pop),
      .data_o  (cmd_rdata),
      .full_o  (cmd_full),
      .empty_o (cmd_empty),
      .count_o (cmd_count)
   );

   // Credit in the ALU keeps pushes below full
   valu_fifo #(.data_t(valu_res_t), .DEPTH(RES_DEPTH)) u_res_fifo (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .push_i  (res_push),
      .data_i  (res_wdata),
      .pop_i   (res_pop),
      .data_o  (res_rdata),
      .full_o  (),
      .empty_o (res_empty),
      .count_o (res_count)
   );

   valu_alu u_alu (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .cmd_data_i  (cmd_rdata),
      .cmd_empty_i (cmd_empty),
      .res_count_i (res_count),
      .cmd_pop_o   (cmd_pop),
      .res_push_o  (res_push),
      .res_data_o  (res_wdata)
   );

endmodule

//--- vlog.f
valu_pkg.sv
valu_fifo.sv
valu_lane.sv
valu_alu.sv
valu_axil_front.sv
valu_top.sv
tb_clkgen.sv
tb_valu.sv
